// File: Bender.yml
package:
  name: rv_core

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/rv_pkg.sv
      - hdl/rv_decode_if.sv
      - hdl/rv_decoder.sv
      - hdl/rv_execute.sv
      - hdl/rv_branch_unit.sv
      - hdl/rv_lsu.sv
      - hdl/rv_hart_state.sv
      - hdl/rv_core.sv
      - target: simulation
        files:
          - sim/tb_rv_core.sv

// File: hdl/rv_branch_unit.sv
/* Next-PC logic; targets only clear bit 0, misaligned targets are not trapped */
`timescale 1ns/100ps
`include "rv_defs.svh"

module rv_branch_unit (
	rv_decode_if.user           dec,
	input  logic [`RV_XLEN-1:0] pc,
	output logic [`RV_XLEN-1:0] pc_next,
	output logic [`RV_XLEN-1:0] pc_plus4
);
	import rv_pkg::*;

	logic                taken;
	logic [`RV_XLEN-1:0] pc_rel;

	assign pc_plus4 = pc + `RV_XLEN'd4;
	assign pc_rel   = pc + dec.imm; // Shared by JAL and branches

	always_comb begin
		case (rv_branch_e'(dec.funct3))
			BR_BEQ:  taken = dec.rs1_value == dec.rs2_value;
			BR_BNE:  taken = dec.rs1_value != dec.rs2_value;
			BR_BLT:  taken = $signed(dec.rs1_value) < $signed(dec.rs2_value);
			BR_BGE:  taken = $signed(dec.rs1_value) >= $signed(dec.rs2_value);
			BR_BLTU: taken = dec.rs1_value < dec.rs2_value;
			BR_BGEU: taken = dec.rs1_value >= dec.rs2_value;
			default: taken = 1'b0;
		endcase
	end

	always_comb begin
		pc_next = pc_plus4;
		if (dec.legal) begin
			case (dec.opcode)
				OPC_JAL:    pc_next = {pc_rel[`RV_XLEN-1:1], 1'b0};
				OPC_JALR:   pc_next = (dec.rs1_value + dec.imm) & ~`RV_XLEN'd1;
				OPC_BRANCH: pc_next = taken ? {pc_rel[`RV_XLEN-1:1], 1'b0} : pc_plus4;
				default:    pc_next = pc_plus4;
			endcase
		end
	end

endmodule

// File: hdl/rv_core.sv
/* Single-cycle RV32I executor with external register file and data memory.
   Request outputs are levels held until the matching ready; no compressed ISA. */
`timescale 1ns/100ps
`include "rv_defs.svh"

module rv_core (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic [`RV_XLEN-1:0]   insn,
	input  logic                  insn_valid,
	output logic [`RV_XLEN-1:0]   insn_addr,
	output logic                  insn_complete,
	output logic                  trap,
	output logic [`RV_REG_AW-1:0] rs1_addr,
	output logic [`RV_REG_AW-1:0] rs2_addr,
	output logic [`RV_REG_AW-1:0] rd_addr,
	output logic                  rs1_addr_valid,
	output logic                  rs2_addr_valid,
	output logic                  rd_addr_valid,
	input  logic [`RV_XLEN-1:0]   rs1_rdata,
	input  logic [`RV_XLEN-1:0]   rs2_rdata,
	output logic [`RV_XLEN-1:0]   rd_wdata,
	input  logic                  rs1_ready,
	input  logic                  rs2_ready,
	input  logic                  rd_ready,
	output logic                  mem_valid,
	input  logic                  mem_ready,
	output logic [`RV_XLEN-1:0]   mem_addr,
	output logic [`RV_XLEN-1:0]   mem_wdata,
	output logic [3:0]            mem_wstrb,
	output logic [3:0]            mem_rmask,
	input  logic [`RV_XLEN-1:0]   mem_rdata,
	input  logic [`RV_CNT_W-1:0]  csr_time
);

	logic [`RV_XLEN-1:0]  pc_next;
	logic [`RV_XLEN-1:0]  pc_plus4;
	logic [`RV_XLEN-1:0]  load_data;
	logic [`RV_CNT_W-1:0] cycle_cnt;
	logic [`RV_CNT_W-1:0] instret_cnt;

	rv_decode_if dec_bus ();

	rv_decoder u_decoder (
		.insn           (insn),
		.insn_valid     (insn_valid),
		.rs1_rdata      (rs1_rdata),
		.rs2_rdata      (rs2_rdata),
		.rs1_ready      (rs1_ready),
		.rs2_ready      (rs2_ready),
		.rd_ready       (rd_ready),
		.mem_ready      (mem_ready),
		.mem_valid      (mem_valid),
		.rs1_addr       (rs1_addr),
		.rs2_addr       (rs2_addr),
		.rd_addr        (rd_addr),
		.rs1_addr_valid (rs1_addr_valid),
		.rs2_addr_valid (rs2_addr_valid),
		.rd_addr_valid  (rd_addr_valid),
		.insn_complete  (insn_complete),
		.trap           (trap),
		.dec            (dec_bus.dec)
	);

	rv_execute u_execute (
		.dec         (dec_bus.user),
		.pc          (insn_addr),
		.pc_plus4    (pc_plus4),
		.load_data   (load_data),
		.cycle_cnt   (cycle_cnt),
		.instret_cnt (instret_cnt),
		.csr_time    (csr_time),
		.rd_wdata    (rd_wdata)
	);

	rv_branch_unit u_branch (
		.dec      (dec_bus.user),
		.pc       (insn_addr),
		.pc_next  (pc_next),
		.pc_plus4 (pc_plus4)
	);

	rv_lsu u_lsu (
		.dec       (dec_bus.user),
		.mem_rdata (mem_rdata),
		.mem_valid (mem_valid),
		.mem_addr  (mem_addr),
		.mem_wdata (mem_wdata),
		.mem_wstrb (mem_wstrb),
		.mem_rmask (mem_rmask),
		.load_data (load_data)
	);

	rv_hart_state u_state (
		.clk           (clk),
		.rst_n         (rst_n),
		.insn_complete (insn_complete),
		.trap          (trap),
		.pc_next       (pc_next),
		.pc            (insn_addr), // pc is the fetch address
		.cycle_cnt     (cycle_cnt),
		.instret_cnt   (instret_cnt)
	);

endmodule

// File: hdl/rv_decode_if.sv
/* Decoded instruction bundle; legal already includes insn_valid */
`timescale 1ns/100ps
`include "rv_defs.svh"

interface rv_decode_if;
	import rv_pkg::*;

	rv_opcode_e         opcode;
	logic [2:0]         funct3;
	logic               alt;       // funct7 bit 5
	logic [`RV_XLEN-1:0] imm;      // Format already selected
	logic [`RV_XLEN-1:0] rs1_value;
	logic [`RV_XLEN-1:0] rs2_value; // Immediate for OP_IMM
	logic [11:0]        csr_sel;
	logic               legal;

	modport dec (output opcode, funct3, alt, imm, rs1_value, rs2_value, csr_sel, legal);

	modport user (input opcode, funct3, alt, imm, rs1_value, rs2_value, csr_sel, legal);

endinterface

// File: hdl/rv_decoder.sv
/* Base RV32I decode only; SYSTEM accepts just the counter reads (CSRRS, rs1 = x0).
   Illegal encodings request no ports, so insn_complete rises together with trap. */
`timescale 1ns/100ps
`include "rv_defs.svh"

module rv_decoder (
	input  logic [`RV_XLEN-1:0]   insn,
	input  logic                  insn_valid,
	input  logic [`RV_XLEN-1:0]   rs1_rdata,
	input  logic [`RV_XLEN-1:0]   rs2_rdata,
	input  logic                  rs1_ready,
	input  logic                  rs2_ready,
	input  logic                  rd_ready,
	input  logic                  mem_ready,
	input  logic                  mem_valid,
	output logic [`RV_REG_AW-1:0] rs1_addr,
	output logic [`RV_REG_AW-1:0] rs2_addr,
	output logic [`RV_REG_AW-1:0] rd_addr,
	output logic                  rs1_addr_valid,
	output logic                  rs2_addr_valid,
	output logic                  rd_addr_valid,
	output logic                  insn_complete,
	output logic                  trap,
	rv_decode_if.dec              dec
);
	import rv_pkg::*;

	rv_opcode_e            opcode;
	logic [2:0]            funct3;
	logic [6:0]            funct7;
	logic [`RV_REG_AW-1:0] f_rs1;
	logic [`RV_REG_AW-1:0] f_rs2;
	logic [`RV_REG_AW-1:0] f_rd;
	logic [11:0]           csr_base;
	logic                  enc_legal;
	logic                  use_rs1;
	logic                  use_rs2;
	logic                  use_rd;
	logic [`RV_XLEN-1:0]   imm;

	assign opcode   = rv_opcode_e'(insn[6:0]);
	assign funct3   = insn[14:12];
	assign funct7   = insn[31:25];
	assign f_rd     = insn[11:7];
	assign f_rs1    = insn[19:15];
	assign f_rs2    = insn[24:20];
	assign csr_base = insn[31:20] & ~`RV_CSR_HI_OFS; // Fold high half onto low

	always_comb begin
		case (opcode)
			OPC_STORE:          imm = {{20{insn[31]}}, insn[31:25], insn[11:7]};
			OPC_BRANCH:         imm = {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
			OPC_LUI, OPC_AUIPC: imm = {insn[31:12], 12'b0};
			OPC_JAL:            imm = {{12{insn[31]}}, insn[19:12], insn[20], insn[30:21], 1'b0};
			default:            imm = {{20{insn[31]}}, insn[31:20]}; // I-type
		endcase
	end

	always_comb begin
		enc_legal = 1'b0;
		use_rs1   = 1'b0;
		use_rs2   = 1'b0;
		use_rd    = 1'b0;
		case (opcode)
			OPC_LUI, OPC_AUIPC, OPC_JAL: begin
				enc_legal = 1'b1;
				use_rd    = 1'b1;
			end
			OPC_JALR: begin
				enc_legal = (funct3 == 3'b000);
				use_rs1   = 1'b1;
				use_rd    = 1'b1;
			end
			OPC_BRANCH: begin
				enc_legal = (funct3 != 3'b010) && (funct3 != 3'b011);
				use_rs1   = 1'b1;
				use_rs2   = 1'b1;
			end
			OPC_LOAD: begin
				enc_legal = (funct3 == W_B) || (funct3 == W_H) || (funct3 == W_W) ||
				            (funct3 == W_BU) || (funct3 == W_HU);
				use_rs1   = 1'b1;
				use_rd    = 1'b1;
			end
			OPC_STORE: begin
				enc_legal = (funct3 == W_B) || (funct3 == W_H) || (funct3 == W_W);
				use_rs1   = 1'b1;
				use_rs2   = 1'b1;
			end
			OPC_OP: begin
				enc_legal = (funct7 == 7'b0000000) ||
				            (funct7 == 7'b0100000 && (funct3 == ALU_ADD || funct3 == ALU_SR));
				use_rs1   = 1'b1;
				use_rs2   = 1'b1;
				use_rd    = 1'b1;
			end
			OPC_OP_IMM: begin
				case (funct3)
					ALU_SLL: enc_legal = (funct7 == 7'b0000000);
					ALU_SR:  enc_legal = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
					default: enc_legal = 1'b1;
				endcase
				use_rs1   = 1'b1;
				use_rd    = 1'b1;
			end
			OPC_SYSTEM: begin
				enc_legal = (f_rs1 == '0) && (funct3 == 3'b010) &&
				            (csr_base == `RV_CSR_CYCLE || csr_base == `RV_CSR_TIME ||
				             csr_base == `RV_CSR_INSTRET);
				use_rd    = 1'b1;
			end
			default: enc_legal = 1'b0;
		endcase
	end

	assign rs1_addr_valid = insn_valid && enc_legal && use_rs1;
	assign rs2_addr_valid = insn_valid && enc_legal && use_rs2;
	assign rd_addr_valid  = insn_valid && enc_legal && use_rd;
	assign rs1_addr       = rs1_addr_valid ? f_rs1 : '0;
	assign rs2_addr       = rs2_addr_valid ? f_rs2 : '0;
	assign rd_addr        = rd_addr_valid ? f_rd : '0;

	assign trap          = insn_valid && !enc_legal;
	assign insn_complete = insn_valid && (!rs1_addr_valid || rs1_ready) &&
	                       (!rs2_addr_valid || rs2_ready) && (!rd_addr_valid || rd_ready) &&
	                       (!mem_valid || mem_ready);

	assign dec.opcode    = opcode;
	assign dec.funct3    = funct3;
	assign dec.alt       = funct7[5];
	assign dec.imm       = imm;
	assign dec.rs1_value = (f_rs1 == '0) ? '0 : rs1_rdata; // x0 reads as zero
	assign dec.rs2_value = (opcode == OPC_OP_IMM) ? imm : (f_rs2 == '0) ? '0 : rs2_rdata;
	assign dec.csr_sel   = insn[31:20];
	assign dec.legal     = insn_valid && enc_legal;

	always_comb begin
		assert final ((rs1_addr_valid || rs1_addr == '0) && (rs2_addr_valid || rs2_addr == '0) &&
		              (rd_addr_valid || rd_addr == '0))
			else $error("Register address nonzero while its valid is low");
	end

endmodule

// File: hdl/rv_defs.svh
/* Shared widths and constants for the RV32I executor.
   Counter CSRs cover the user read-only low and high halves only. */
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

`define RV_XLEN        32
`define RV_REG_AW      5
`define RV_CNT_W       64

`define RV_RESET_PC    32'h0000_0000

// Low-half counter numbers, high half sits at +HI_OFS
`define RV_CSR_CYCLE   12'hC00
`define RV_CSR_TIME    12'hC01
`define RV_CSR_INSTRET 12'hC02
`define RV_CSR_HI_OFS  12'h080

`endif

// File: hdl/rv_execute.sv
/* Integer ALU and rd write-back select; rd_wdata is zero for illegal or idle cycles */
`timescale 1ns/100ps
`include "rv_defs.svh"

module rv_execute (
	rv_decode_if.user            dec,
	input  logic [`RV_XLEN-1:0]  pc,
	input  logic [`RV_XLEN-1:0]  pc_plus4,
	input  logic [`RV_XLEN-1:0]  load_data,
	input  logic [`RV_CNT_W-1:0] cycle_cnt,
	input  logic [`RV_CNT_W-1:0] instret_cnt,
	input  logic [`RV_CNT_W-1:0] csr_time,
	output logic [`RV_XLEN-1:0]  rd_wdata
);
	import rv_pkg::*;

	logic [`RV_XLEN-1:0]  op_a;
	logic [`RV_XLEN-1:0]  op_b;
	logic [4:0]           shamt;
	logic                 sub_op;
	logic [`RV_XLEN-1:0]  sra_res;
	logic [`RV_XLEN-1:0]  alu_res;
	logic [`RV_CNT_W-1:0] cnt_sel;
	logic [`RV_XLEN-1:0]  cnt_half;

	assign op_a    = dec.rs1_value;
	assign op_b    = dec.rs2_value;
	assign shamt   = op_b[4:0];
	assign sub_op  = (dec.opcode == OPC_OP) && dec.alt; // ADDI has no subtract form
	assign sra_res = $signed(op_a) >>> shamt;

	always_comb begin
		case (rv_alu_e'(dec.funct3))
			ALU_ADD:  alu_res = sub_op ? op_a - op_b : op_a + op_b;
			ALU_SLL:  alu_res = op_a << shamt;
			ALU_SLT:  alu_res = {{(`RV_XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
			ALU_SLTU: alu_res = {{(`RV_XLEN-1){1'b0}}, op_a < op_b};
			ALU_XOR:  alu_res = op_a ^ op_b;
			ALU_SR:   alu_res = dec.alt ? sra_res : op_a >> shamt;
			ALU_OR:   alu_res = op_a | op_b;
			default:  alu_res = op_a & op_b;
		endcase
	end

	always_comb begin
		case (dec.csr_sel & ~`RV_CSR_HI_OFS)
			`RV_CSR_CYCLE: cnt_sel = cycle_cnt;
			`RV_CSR_TIME:  cnt_sel = csr_time;
			default:       cnt_sel = instret_cnt;
		endcase
	end

	assign cnt_half = ((dec.csr_sel & `RV_CSR_HI_OFS) != '0) ?
	                  cnt_sel[`RV_CNT_W-1:`RV_XLEN] : cnt_sel[`RV_XLEN-1:0];

	always_comb begin
		rd_wdata = '0;
		if (dec.legal) begin
			case (dec.opcode)
				OPC_LUI:            rd_wdata = dec.imm;
				OPC_AUIPC:          rd_wdata = pc + dec.imm;
				OPC_JAL, OPC_JALR:  rd_wdata = pc_plus4;      // Link address
				OPC_LOAD:           rd_wdata = load_data;
				OPC_OP, OPC_OP_IMM: rd_wdata = alu_res;
				OPC_SYSTEM:         rd_wdata = cnt_half;
				default:            rd_wdata = '0;
			endcase
		end
	end

endmodule

// File: hdl/rv_hart_state.sv
/* PC and 64-bit counters; a trapping instruction leaves pc and instret unchanged */
`timescale 1ns/100ps
`include "rv_defs.svh"

module rv_hart_state (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 insn_complete,
	input  logic                 trap,
	input  logic [`RV_XLEN-1:0]  pc_next,
	output logic [`RV_XLEN-1:0]  pc,
	output logic [`RV_CNT_W-1:0] cycle_cnt,
	output logic [`RV_CNT_W-1:0] instret_cnt
);

	logic retire;

	assign retire = insn_complete && !trap;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc          <= `RV_RESET_PC;
			cycle_cnt   <= '0;
			instret_cnt <= '0;
		end else begin
			cycle_cnt <= cycle_cnt + 1'b1; // Every edge out of reset
			if (retire) begin
				pc          <= {pc_next[`RV_XLEN-1:1], 1'b0};
				instret_cnt <= instret_cnt + 1'b1;
			end
		end
	end

	a_pc_aligned: assert property (@(posedge clk) disable iff (!rst_n) !pc[0])
		else $error("pc bit 0 set");

endmodule

// File: hdl/rv_lsu.sv
/* Data memory port; masks always use the low lanes and the address is not aligned.
   Outputs hold steady while the decoded inputs are steady. */
`timescale 1ns/100ps
`include "rv_defs.svh"

module rv_lsu (
	rv_decode_if.user           dec,
	input  logic [`RV_XLEN-1:0] mem_rdata,
	output logic                mem_valid,
	output logic [`RV_XLEN-1:0] mem_addr,
	output logic [`RV_XLEN-1:0] mem_wdata,
	output logic [3:0]          mem_wstrb,
	output logic [3:0]          mem_rmask,
	output logic [`RV_XLEN-1:0] load_data
);
	import rv_pkg::*;

	logic       is_load;
	logic       is_store;
	logic [3:0] lane_mask;

	assign is_load  = dec.legal && (dec.opcode == OPC_LOAD);
	assign is_store = dec.legal && (dec.opcode == OPC_STORE);

	always_comb begin
		case (dec.funct3[1:0])
			2'b00:   lane_mask = 4'b0001;
			2'b01:   lane_mask = 4'b0011;
			default: lane_mask = 4'b1111;
		endcase
	end

	assign mem_valid = is_load || is_store;
	assign mem_addr  = mem_valid ? dec.rs1_value + dec.imm : '0;
	assign mem_wdata = is_store ? dec.rs2_value : '0;
	assign mem_wstrb = is_store ? lane_mask : 4'b0000;
	assign mem_rmask = is_load ? lane_mask : 4'b0000;

	always_comb begin
		case (rv_width_e'(dec.funct3))
			W_B:     load_data = {{(`RV_XLEN-8){mem_rdata[7]}}, mem_rdata[7:0]};
			W_H:     load_data = {{(`RV_XLEN-16){mem_rdata[15]}}, mem_rdata[15:0]};
			W_BU:    load_data = {{(`RV_XLEN-8){1'b0}}, mem_rdata[7:0]};
			W_HU:    load_data = {{(`RV_XLEN-16){1'b0}}, mem_rdata[15:0]};
			default: load_data = mem_rdata; // Word
		endcase
	end

	always_comb begin
		assert final (!((|mem_wstrb) && (|mem_rmask)))
			else $error("Write strobe and read mask active together");
	end

endmodule

// File: hdl/rv_pkg.sv
/* Encodings for the RV32I base set; no compressed or extension opcodes */
package rv_pkg;

	typedef enum logic [6:0] {
		OPC_LUI    = 7'b0110111,
		OPC_AUIPC  = 7'b0010111,
		OPC_JAL    = 7'b1101111,
		OPC_JALR   = 7'b1100111,
		OPC_BRANCH = 7'b1100011,
		OPC_LOAD   = 7'b0000011,
		OPC_STORE  = 7'b0100011,
		OPC_OP     = 7'b0110011,
		OPC_OP_IMM = 7'b0010011,
		OPC_SYSTEM = 7'b1110011
	} rv_opcode_e;

	typedef enum logic [2:0] {
		BR_BEQ  = 3'b000,
		BR_BNE  = 3'b001,
		BR_BLT  = 3'b100,
		BR_BGE  = 3'b101,
		BR_BLTU = 3'b110,
		BR_BGEU = 3'b111
	} rv_branch_e;

	typedef enum logic [2:0] {
		W_B = 3'b000, W_H = 3'b001, W_W = 3'b010, W_BU = 3'b100, W_HU = 3'b101
	} rv_width_e;

	typedef enum logic [2:0] {
		ALU_ADD = 3'b000, ALU_SLL = 3'b001, ALU_SLT = 3'b010, ALU_SLTU = 3'b011,
		ALU_XOR = 3'b100, ALU_SR  = 3'b101, ALU_OR  = 3'b110, ALU_AND  = 3'b111
	} rv_alu_e;

endpackage

// File: sim/tb_rv_core.sv
/* Register file and memory models answer each request with the current row's data.
   The testbench tracks the PC from reset, so the rows depend on their order. */
`timescale 1ns/100ps
`include "rv_defs.svh"

module tb_rv_core;
	import rv_pkg::*;

	localparam int sel_fixed   = 0;
	localparam int sel_cycle   = 1;
	localparam int sel_instret = 2;
	localparam int sel_pc      = 3;
	localparam int nxt_seq     = 0;
	localparam int nxt_rel     = 1;
	localparam int nxt_abs     = 2;
	localparam logic [63:0] time_value = 64'h0123_4567_89AB_CDEF;
	localparam logic [31:0] ld_word    = 32'h8765_80F1;
	localparam logic [31:0] st_word    = 32'hCAFE_BABE;

	logic        clk;
	logic        rst_n;
	logic [31:0] insn;
	logic        insn_valid;
	logic [31:0] insn_addr;
	logic        insn_complete;
	logic        trap;
	logic [4:0]  rs1_addr;
	logic [4:0]  rs2_addr;
	logic [4:0]  rd_addr;
	logic        rs1_addr_valid;
	logic        rs2_addr_valid;
	logic        rd_addr_valid;
	logic [31:0] rs1_rdata;
	logic [31:0] rs2_rdata;
	logic [31:0] rd_wdata;
	logic        rs1_ready;
	logic        rs2_ready;
	logic        rd_ready;
	logic        mem_valid;
	logic        mem_ready;
	logic [31:0] mem_addr;
	logic [31:0] mem_wdata;
	logic [3:0]  mem_wstrb;
	logic [3:0]  mem_rmask;
	logic [31:0] mem_rdata;
	logic [63:0] csr_time;

	integer      seed = 32'h26a0_fb37;
	logic [63:0] cycles_seen = '0; // Rising edges since reset release
	int          retired = 0;
	logic [31:0] pc_model = `RV_RESET_PC;
	int          n_rows = 0;

	string       row_name [0:63];
	logic [31:0] row_insn [0:63];
	logic [31:0] row_a [0:63];
	logic [31:0] row_b [0:63];
	logic [31:0] row_mem [0:63];
	int          row_mode [0:63]; // 1 means random ready delay
	int          row_sel [0:63];
	logic [31:0] row_rd [0:63];
	logic [31:0] row_addr [0:63];
	logic [3:0]  row_wstrb [0:63];
	logic [3:0]  row_rmask [0:63];
	logic [31:0] row_wdata [0:63];
	logic        row_trap [0:63];
	int          row_nk [0:63];
	logic [31:0] row_tgt [0:63];

	rv_core DUT (
		.clk            (clk),
		.rst_n          (rst_n),
		.insn           (insn),
		.insn_valid     (insn_valid),
		.insn_addr      (insn_addr),
		.insn_complete  (insn_complete),
		.trap           (trap),
		.rs1_addr       (rs1_addr),
		.rs2_addr       (rs2_addr),
		.rd_addr        (rd_addr),
		.rs1_addr_valid (rs1_addr_valid),
		.rs2_addr_valid (rs2_addr_valid),
		.rd_addr_valid  (rd_addr_valid),
		.rs1_rdata      (rs1_rdata),
		.rs2_rdata      (rs2_rdata),
		.rd_wdata       (rd_wdata),
		.rs1_ready      (rs1_ready),
		.rs2_ready      (rs2_ready),
		.rd_ready       (rd_ready),
		.mem_valid      (mem_valid),
		.mem_ready      (mem_ready),
		.mem_addr       (mem_addr),
		.mem_wdata      (mem_wdata),
		.mem_wstrb      (mem_wstrb),
		.mem_rmask      (mem_rmask),
		.mem_rdata      (mem_rdata),
		.csr_time       (csr_time)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		if (!rst_n)
			cycles_seen <= '0;
		else
			cycles_seen <= cycles_seen + 1'b1;
	end

	function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
			input logic [4:0] rs2, rs1);
		return {f7, rs2, rs1, f3, 5'd3, OPC_OP}; // rd is x3
	endfunction

	function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
			input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [2:0] f3);
		return {imm[11:5], 5'd2, 5'd1, f3, imm[4:0], OPC_STORE};
	endfunction

	function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [2:0] f3);
		return {imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11], OPC_BRANCH};
	endfunction

	function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [6:0] opc);
		return {imm, 5'd3, opc};
	endfunction

	function automatic logic [31:0] j_type(input logic [20:0] imm);
		return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd1, OPC_JAL};
	endfunction

	// Bit 0 rs1, bit 1 rs2, bit 2 rd, bit 3 data memory
	function automatic logic [3:0] ports_used(input logic [31:0] word);
		case (word[6:0])
			OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_SYSTEM: return 4'b0100;
			OPC_JALR, OPC_OP_IMM:                    return 4'b0101;
			OPC_BRANCH:                              return 4'b0011;
			OPC_LOAD:                                return 4'b1101;
			OPC_STORE:                               return 4'b1011;
			OPC_OP:                                  return 4'b0111;
			default:                                 return 4'b0000;
		endcase
	endfunction

	task automatic check_value(input string what, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			$display("FAIL %s: expected %h, actual %h", what, expected, actual);
			$display("Checks failed");
			$fatal(1, "Stopped at the first mismatch");
		end
	endtask

	task automatic report_timeout(input string what);
		$display("Timed out waiting for insn_complete or trap on %s", what);
		$display("Checks failed");
		$fatal(1, "Stopped on timeout");
	endtask

	task automatic new_row(input string name, input logic [31:0] word, a, b, input int mode);
		row_name[n_rows]  = name;
		row_insn[n_rows]  = word;
		row_a[n_rows]     = a;
		row_b[n_rows]     = b;
		row_mode[n_rows]  = mode;
		row_mem[n_rows]   = '0;
		row_sel[n_rows]   = sel_fixed;
		row_rd[n_rows]    = '0;
		row_addr[n_rows]  = '0;
		row_wstrb[n_rows] = '0;
		row_rmask[n_rows] = '0;
		row_wdata[n_rows] = '0;
		row_trap[n_rows]  = 1'b0;
		row_nk[n_rows]    = nxt_seq;
		row_tgt[n_rows]   = '0;
		n_rows++;
	endtask

	task automatic alu_row(input string name, input logic [31:0] word, a, b,
			input int mode, sel, input logic [31:0] rd);
		new_row(name, word, a, b, mode);
		row_sel[n_rows-1] = sel;
		row_rd[n_rows-1]  = rd;
	endtask

	task automatic branch_row(input string name, input logic [31:0] word, a, b,
			input int mode, input logic taken, input logic [31:0] ofs);
		new_row(name, word, a, b, mode);
		row_nk[n_rows-1]  = taken ? nxt_rel : nxt_seq;
		row_tgt[n_rows-1] = ofs;
	endtask

	task automatic jump_row(input string name, input logic [31:0] word, a,
			input int mode, nk, input logic [31:0] tgt);
		new_row(name, word, a, 32'h0, mode);
		row_sel[n_rows-1] = sel_pc;
		row_rd[n_rows-1]  = 32'd4; // Link is pc+4
		row_nk[n_rows-1]  = nk;
		row_tgt[n_rows-1] = tgt;
	endtask

	task automatic mem_row(input string name, input logic [31:0] word, a, b, data,
			input int mode, input logic store, input logic [3:0] mask,
			input logic [31:0] addr, rd);
		new_row(name, word, a, b, mode);
		row_mem[n_rows-1]   = data;
		row_rd[n_rows-1]    = rd;
		row_addr[n_rows-1]  = addr;
		row_wstrb[n_rows-1] = store ? mask : 4'b0000;
		row_rmask[n_rows-1] = store ? 4'b0000 : mask;
		row_wdata[n_rows-1] = store ? b : 32'h0; // Store data is rs2
	endtask

	task automatic trap_row(input string name, input logic [31:0] word, input int mode);
		new_row(name, word, 32'h1234_5678, 32'h9ABC_DEF0, mode);
		row_trap[n_rows-1] = 1'b1;
	endtask

	task automatic build_table;
		alu_row("add", r_type(7'h00, 3'b000, 2, 1), 32'd5, 32'd7, 0, sel_fixed, 32'd12);
		alu_row("sub", r_type(7'h20, 3'b000, 2, 1), 32'd5, 32'd7, 1, sel_fixed, 32'hFFFF_FFFE);
		alu_row("sll", r_type(7'h00, 3'b001, 2, 1), 32'h1, 32'h24, 0, sel_fixed, 32'h10);
		alu_row("slt", r_type(7'h00, 3'b010, 2, 1), 32'hFFFF_FFFF, 32'd1, 0, sel_fixed, 32'd1);
		alu_row("sltu", r_type(7'h00, 3'b011, 2, 1), 32'hFFFF_FFFF, 32'd1, 0, sel_fixed, 32'd0);
		alu_row("xor", r_type(7'h00, 3'b100, 2, 1), 32'hF0F0_F0F0, 32'h0FF0_0FF0, 0, sel_fixed,
			32'hFF00_FF00);
		alu_row("srl", r_type(7'h00, 3'b101, 2, 1), 32'h8000_0000, 32'd4, 0, sel_fixed,
			32'h0800_0000);
		alu_row("sra", r_type(7'h20, 3'b101, 2, 1), 32'h8000_0000, 32'd4, 1, sel_fixed,
			32'hF800_0000);
		alu_row("or", r_type(7'h00, 3'b110, 2, 1), 32'hF0, 32'h0F, 0, sel_fixed, 32'hFF);
		alu_row("and", r_type(7'h00, 3'b111, 2, 1), 32'hFF00_FF00, 32'h0F0F_0F0F, 0, sel_fixed,
			32'h0F00_0F00);
		alu_row("add x0 rs2", r_type(7'h00, 3'b000, 0, 1), 32'h55, 32'h99, 0, sel_fixed, 32'h55);
		alu_row("addi", i_type(12'hFFF, 1, 3'b000, 3, OPC_OP_IMM), 32'd10, 0, 0, sel_fixed, 32'd9);
		alu_row("addi x0", i_type(12'h123, 0, 3'b000, 3, OPC_OP_IMM), 32'hDEAD_BEEF, 0, 1,
			sel_fixed, 32'h123);
		alu_row("slti", i_type(12'hFFE, 1, 3'b010, 3, OPC_OP_IMM), 32'hFFFF_FFFD, 0, 0,
			sel_fixed, 32'd1);
		alu_row("sltiu", i_type(12'hFFF, 1, 3'b011, 3, OPC_OP_IMM), 32'd5, 0, 0, sel_fixed, 32'd1);
		alu_row("srai", i_type(12'h408, 1, 3'b101, 3, OPC_OP_IMM), 32'h8000_1000, 0, 0,
			sel_fixed, 32'hFF80_0010);
		alu_row("lui", u_type(20'h12345, OPC_LUI), 0, 0, 0, sel_fixed, 32'h1234_5000);
		alu_row("auipc", u_type(20'h00001, OPC_AUIPC), 0, 0, 1, sel_pc, 32'h1000);

		branch_row("beq taken", b_type(13'd8, 3'b000), 32'd3, 32'd3, 0, 1, 32'd8);
		branch_row("beq not", b_type(13'd8, 3'b000), 32'd3, 32'd4, 0, 0, 32'd8);
		branch_row("bne taken", b_type(13'h1FFC, 3'b001), 32'd3, 32'd4, 1, 1, 32'hFFFF_FFFC);
		branch_row("bne not", b_type(13'h1FFC, 3'b001), 32'd3, 32'd3, 0, 0, 32'hFFFF_FFFC);
		branch_row("blt taken", b_type(13'd8, 3'b100), 32'hFFFF_FFFF, 32'd1, 0, 1, 32'd8);
		branch_row("blt not", b_type(13'd8, 3'b100), 32'd1, 32'hFFFF_FFFF, 0, 0, 32'd8);
		branch_row("bge taken", b_type(13'd8, 3'b101), 32'd1, 32'hFFFF_FFFF, 1, 1, 32'd8);
		branch_row("bge not", b_type(13'd8, 3'b101), 32'hFFFF_FFFF, 32'd1, 0, 0, 32'd8);
		branch_row("bltu taken", b_type(13'd8, 3'b110), 32'd1, 32'hFFFF_FFFF, 0, 1, 32'd8);
		branch_row("bltu not", b_type(13'd8, 3'b110), 32'hFFFF_FFFF, 32'd1, 0, 0, 32'd8);
		branch_row("bgeu taken", b_type(13'd8, 3'b111), 32'hFFFF_FFFF, 32'd1, 0, 1, 32'd8);
		branch_row("bgeu not", b_type(13'd8, 3'b111), 32'd1, 32'hFFFF_FFFF, 1, 0, 32'd8);
		jump_row("jal", j_type(21'd16), 0, 0, nxt_rel, 32'd16);
		jump_row("jalr", i_type(12'h005, 2, 3'b000, 1, OPC_JALR), 32'h100, 1, nxt_abs, 32'h105);

		mem_row("lb", i_type(12'h008, 1, 3'b000, 3, OPC_LOAD), 32'h1000, 0, ld_word, 0, 0,
			4'b0001, 32'h1008, 32'hFFFF_FFF1);
		mem_row("lh", i_type(12'h008, 1, 3'b001, 3, OPC_LOAD), 32'h1000, 0, ld_word, 0, 0,
			4'b0011, 32'h1008, 32'hFFFF_80F1);
		mem_row("lw", i_type(12'h008, 1, 3'b010, 3, OPC_LOAD), 32'h1000, 0, ld_word, 1, 0,
			4'b1111, 32'h1008, ld_word);
		mem_row("lbu", i_type(12'h008, 1, 3'b100, 3, OPC_LOAD), 32'h1000, 0, ld_word, 0, 0,
			4'b0001, 32'h1008, 32'hF1);
		mem_row("lhu", i_type(12'hFFC, 1, 3'b101, 3, OPC_LOAD), 32'h1000, 0, ld_word, 0, 0,
			4'b0011, 32'h0FFC, 32'h80F1);
		mem_row("sb", s_type(12'h010, 3'b000), 32'h2000, st_word, 0, 0, 1, 4'b0001, 32'h2010, 0);
		mem_row("sh", s_type(12'h010, 3'b001), 32'h2000, st_word, 0, 1, 1, 4'b0011, 32'h2010, 0);
		mem_row("sw", s_type(12'h010, 3'b010), 32'h2000, st_word, 0, 1, 1, 4'b1111, 32'h2010, 0);

		trap_row("branch f3 010", b_type(13'd8, 3'b010), 0);
		trap_row("ecall", 32'h0000_0073, 1);
		trap_row("csrrw cycle", i_type(12'hC00, 0, 3'b001, 3, OPC_SYSTEM), 0);
		trap_row("opcode zero", 32'h0000_0000, 0);

		alu_row("rdcycle", i_type(12'hC00, 0, 3'b010, 3, OPC_SYSTEM), 0, 0, 1, sel_cycle, 0);
		alu_row("rdinstret", i_type(12'hC02, 0, 3'b010, 3, OPC_SYSTEM), 0, 0, 0, sel_instret, 0);
		alu_row("rdtime", i_type(12'hC01, 0, 3'b010, 3, OPC_SYSTEM), 0, 0, 0, sel_fixed,
			time_value[31:0]);
		alu_row("rdtimeh", i_type(12'hC81, 0, 3'b010, 3, OPC_SYSTEM), 0, 0, 1, sel_fixed,
			time_value[63:32]);
		alu_row("rdcycleh", i_type(12'hC80, 0, 3'b010, 3, OPC_SYSTEM), 0, 0, 0, sel_fixed, 0);
		alu_row("rdinstreth", i_type(12'hC82, 0, 3'b010, 3, OPC_SYSTEM), 0, 0, 0, sel_fixed, 0);
	endtask

	task automatic drive_readies(input logic hold, input logic [3:0] used);
		logic [31:0] rnd;
		logic [3:0]  rdy;
		rnd = $random(seed);
		rdy = rnd[3:0];
		if (!hold)
			rdy = 4'b1111;
		else if ((rdy & used) == used)
			rdy = rdy & ~used; // Keep a used port stalled
		rs1_ready = rdy[0];
		rs2_ready = rdy[1];
		rd_ready  = rdy[2];
		mem_ready = rdy[3];
	endtask

	task automatic run_row(input int i);
		int          cyc;
		int          stall_len;
		logic [3:0]  used;
		logic [3:0]  exp_req;
		logic [31:0] exp_rd;
		logic [31:0] exp_next;
		used = ports_used(row_insn[i]);
		stall_len = (row_mode[i] == 1) ? ({$random(seed)} % 4) + 1 : 0;
		cyc = 0;
		@(negedge clk);
		insn       = row_insn[i];
		insn_valid = 1'b1;
		rs1_rdata  = row_a[i];     // Register file answers from the row
		rs2_rdata  = row_b[i];
		mem_rdata  = row_mem[i];
		drive_readies(stall_len > 0, used);
		#1;
		while (!insn_complete && !trap) begin
			check_value({row_name[i], " pc during stall"}, pc_model, insn_addr);
			cyc++;
			if (cyc > 16)
				report_timeout(row_name[i]);
			@(negedge clk);
			drive_readies(cyc < stall_len, used);
			#1;
		end
		check_value({row_name[i], " wait cycles"}, row_trap[i] ? 0 : stall_len, cyc);

		case (row_sel[i])
			sel_cycle:   exp_rd = cycles_seen[31:0];
			sel_instret: exp_rd = retired;
			sel_pc:      exp_rd = pc_model + row_rd[i];
			default:     exp_rd = row_rd[i];
		endcase
		exp_req = row_trap[i] ? 4'b0000 : used; // Illegal words request nothing
		check_value({row_name[i], " insn_complete"}, 1'b1, insn_complete);
		check_value({row_name[i], " trap"}, row_trap[i], trap);
		check_value({row_name[i], " port valids"}, exp_req,
			{mem_valid, rd_addr_valid, rs2_addr_valid, rs1_addr_valid});
		check_value({row_name[i], " rs1_addr"}, exp_req[0] ? row_insn[i][19:15] : 5'd0,
			rs1_addr);
		check_value({row_name[i], " rs2_addr"}, exp_req[1] ? row_insn[i][24:20] : 5'd0,
			rs2_addr);
		check_value({row_name[i], " rd_addr"}, exp_req[2] ? row_insn[i][11:7] : 5'd0, rd_addr);
		check_value({row_name[i], " rd_wdata"}, exp_rd, rd_wdata);
		check_value({row_name[i], " mem_addr"}, row_addr[i], mem_addr);
		check_value({row_name[i], " mem_wstrb"}, row_wstrb[i], mem_wstrb);
		check_value({row_name[i], " mem_rmask"}, row_rmask[i], mem_rmask);
		check_value({row_name[i], " mem_wdata"}, row_wdata[i], mem_wdata);

		if (row_trap[i])
			exp_next = pc_model;       // Trap leaves the PC
		else if (row_nk[i] == nxt_rel)
			exp_next = (pc_model + row_tgt[i]) & ~32'd1;
		else if (row_nk[i] == nxt_abs)
			exp_next = row_tgt[i] & ~32'd1;
		else
			exp_next = pc_model + 32'd4;

		@(negedge clk);
		insn_valid = 1'b0;
		drive_readies(1'b0, 4'b0000);
		#1;
		check_value({row_name[i], " next insn_addr"}, exp_next, insn_addr);
		check_value({row_name[i], " idle outputs"}, 6'b0,
			{insn_complete, trap, mem_valid, rs1_addr_valid, rs2_addr_valid, rd_addr_valid});
		pc_model = exp_next;
		if (!row_trap[i])
			retired++;
	endtask

	initial begin
		int i;
		rst_n      = 1'b0;
		insn       = '0;
		insn_valid = 1'b0;
		rs1_rdata  = '0;
		rs2_rdata  = '0;
		rs1_ready  = 1'b1;
		rs2_ready  = 1'b1;
		rd_ready   = 1'b1;
		mem_ready  = 1'b1;
		mem_rdata  = '0;
		csr_time   = time_value;
		build_table();
		repeat (10) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		#1;
		check_value("reset insn_addr", pc_model, insn_addr);
		for (i = 0; i < n_rows; i++)
			run_row(i);
		$display("All checks passed");
		$finish;
	end

endmodule

// File: verilog.f
+incdir+hdl
hdl/rv_pkg.sv
hdl/rv_decode_if.sv
hdl/rv_decoder.sv
hdl/rv_execute.sv
hdl/rv_branch_unit.sv
hdl/rv_lsu.sv
hdl/rv_hart_state.sv
hdl/rv_core.sv
sim/tb_rv_core.sv
